//--- Makefile
TOP := tb_pcie_stream

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the simulation, log to sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- bench/stream_props.sv
`timescale 1ns/1ps

module stream_props (
  input logic                       PIPE_PCLK_IN,
  input logic                       clock_locked,
  input pcie_stream_pkg::app_beat_t out_beat_i,
  input logic                       out_valid_i,
  input logic                       out_ready_i,
  input logic                       in_ready_i,
  input logic                       link_up_i
);

  // ------------------------------
  // output handshake
  // ------------------------------

  // offered beat holds until taken
  a_out_hold: assert property (@(posedge PIPE_PCLK_IN) disable iff (!clock_locked)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_beat_i))
    else $error("output beat changed or dropped while not ready");

  // ------------------------------
  // link gating
  // ------------------------------

  a_ready_needs_link: assert property (@(posedge PIPE_PCLK_IN) disable iff (!clock_locked)
    !link_up_i |-> !in_ready_i)
    else $error("input ready high while link is down");

  a_no_out_before_link: assert property (@(posedge PIPE_PCLK_IN) disable iff (!clock_locked)
    !link_up_i |-> !out_valid_i)
    else $error("output valid before link up");

endmodule

bind pcie_stream_top stream_props u_stream_props (
  .PIPE_PCLK_IN(PIPE_PCLK_IN),
  .clock_locked(clock_locked),
  .out_beat_i  (out_beat_o),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .in_ready_i  (in_ready_o),
  .link_up_i   (link_up_o)
);

//--- bench/tb_pcie_stream.sv
`timescale 1ns/1ps

module tb_pcie_stream;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 5;
  localparam int SETTLE       = 8;
  localparam int NUM_PKTS     = 10;
  localparam int TAIL_CYCLES  = 6;

  // one packet of the stimulus table
  typedef struct packed {
    int                                     len;
    // upper keep bits of the last beat, zero means upper half empty
    logic [3:0]                             hi_keep;
    logic [pcie_stream_pkg::USER_WIDTH-1:0] user;
    // percent of cycles with output ready
    int                                     ready_pct;
  } pkt_entry_t;

  logic                       PIPE_PCLK_IN;
  logic                       clock_locked;
  pcie_stream_pkg::app_beat_t in_beat_i;
  logic                       in_valid_i;
  logic                       in_ready_o;
  pcie_stream_pkg::app_beat_t out_beat_o;
  logic                       out_valid_o;
  logic                       out_ready_i;
  logic                       link_up_o;

  pkt_entry_t                 pkt_table [NUM_PKTS];
  pcie_stream_pkg::app_beat_t in_q[$];
  pcie_stream_pkg::app_beat_t exp_q[$];
  int                         exp_pkt_q[$];
  int                         in_idx;
  int                         got_count;
  int                         total_beats;
  logic [31:0]                lcg_state;

  pcie_stream_top #(
    .LINK_SETTLE_CYCLES(SETTLE)
  ) UUT (
    .PIPE_PCLK_IN(PIPE_PCLK_IN),
    .clock_locked(clock_locked),
    .in_beat_i   (in_beat_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_beat_o  (out_beat_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .link_up_o   (link_up_o)
  );

  // ------------------------------
  // clock and watchdog
  // ------------------------------

  initial begin
    PIPE_PCLK_IN = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) PIPE_PCLK_IN = ~PIPE_PCLK_IN;
    end
  end

  initial begin
    #(NUM_PKTS * 40 * CLK_PERIOD);
    $display("watchdog expired, %0d of %0d beats received", got_count, total_beats);
    abort_run();
  end

  // ------------------------------
  // helpers
  // ------------------------------

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_beat(string name, pcie_stream_pkg::app_beat_t got,
                            pcie_stream_pkg::app_beat_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // input beats and the beats expected back, from the table
  task automatic build_stimulus();
    pcie_stream_pkg::app_beat_t beat;
    pcie_stream_pkg::app_beat_t exp;
    for (int p = 0; p < NUM_PKTS; p++) begin
      for (int b = 0; b < pkt_table[p].len; b++) begin
        beat.data = {lcg_next(), lcg_next()};
        beat.keep = 8'hFF;
        beat.last = (b == pkt_table[p].len - 1);
        beat.user = pkt_table[p].user;
        if (beat.last) begin
          beat.keep[7:4] = pkt_table[p].hi_keep;
        end
        exp = beat;
        // empty upper half never crosses the lane, comes back as zeros
        if (beat.last && pkt_table[p].hi_keep == 4'h0) begin
          exp.data[63:32] = '0;
        end
        in_q.push_back(beat);
        exp_q.push_back(exp);
        exp_pkt_q.push_back(p);
      end
    end
    total_beats = exp_q.size();
  endtask

  // output ready follows the duty of the packet at the output
  function automatic logic pick_out_ready();
    int pct;
    if (exp_pkt_q.size() == 0) begin
      return 1'b1;
    end
    pct = pkt_table[exp_pkt_q[0]].ready_pct;
    return (int'((lcg_next() >> 8) % 32'd100) < pct);
  endfunction

  // one clock: drive on the falling edge, then judge the coming rising edge
  task automatic step_cycle();
    @(negedge PIPE_PCLK_IN);
    if (in_idx < in_q.size()) begin
      in_beat_i  = in_q[in_idx];
      in_valid_i = 1'b1;
    end else begin
      in_beat_i  = '0;
      in_valid_i = 1'b0;
    end
    out_ready_i = pick_out_ready();
    #1;
    if (out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("extra output beat at %0t ns with nothing left to expect", $time);
        abort_run();
      end else begin
        check_beat("out_beat_o", out_beat_o, exp_q.pop_front());
        void'(exp_pkt_q.pop_front());
        got_count++;
      end
    end
    if (in_valid_i && in_ready_o) begin
      in_idx++;
    end
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    lcg_state    = 32'd77855;
    clock_locked = 1'b0;
    in_beat_i    = '0;
    in_valid_i   = 1'b0;
    out_ready_i  = 1'b0;
    in_idx       = 0;
    got_count    = 0;

    // len, upper keep of last beat, user, output ready percent
    pkt_table = '{
      '{1, 4'hF, 5'h01, 100},
      '{3, 4'hF, 5'h02, 100},
      '{2, 4'h0, 5'h03, 100},
      '{1, 4'h0, 5'h04, 100},
      '{4, 4'h3, 5'h05, 50},
      '{2, 4'h0, 5'h06, 30},
      '{5, 4'hF, 5'h07, 70},
      '{3, 4'h0, 5'h1F, 20},
      '{6, 4'h7, 5'h10, 60},
      '{1, 4'h0, 5'h0A, 40}
    };
    build_stimulus();

    repeat (RESET_CYCLES) begin
      @(negedge PIPE_PCLK_IN);
      check_bit("link_up_o", link_up_o, 1'b0);
      check_bit("out_valid_o", out_valid_o, 1'b0);
      check_bit("in_ready_o", in_ready_o, 1'b0);
    end
    clock_locked = 1'b1;

    // first beat already offered while the link is still down
    for (int k = 1; k <= SETTLE + 1; k++) begin
      step_cycle();
      check_bit("link_up_o", link_up_o, k >= SETTLE + 1);
      check_bit("in_ready_o", in_ready_o, k >= SETTLE + 1);
      check_bit("out_valid_o", out_valid_o, 1'b0);
    end

    while (exp_q.size() > 0) begin
      step_cycle();
    end

    // stream drained, nothing more may come out
    repeat (TAIL_CYCLES) begin
      step_cycle();
      check_bit("out_valid_o", out_valid_o, 1'b0);
      check_bit("in_ready_o", in_ready_o, 1'b1);
      check_bit("link_up_o", link_up_o, 1'b1);
    end

    if (got_count == total_beats && in_idx == total_beats) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("beat count wrong, sent %0d received %0d of %0d",
               in_idx, got_count, total_beats);
      abort_run();
    end
  end

endmodule

//--- list.f
logic/pcie_stream_pkg.sv
logic/lock_link_ctrl.sv
logic/axis_width_down.sv
logic/axis_width_up.sv
logic/pcie_stream_top.sv
bench/stream_props.sv
bench/tb_pcie_stream.sv

//--- logic/axis_width_down.sv
`timescale 1ns/1ps

module axis_width_down (
  input  logic                       PIPE_PCLK_IN,
  input  logic                       clock_locked,
  input  logic                       link_up_i,

  input  pcie_stream_pkg::app_beat_t  s_beat_i,
  input  logic                       s_valid_i,
  output logic                       s_ready_o,

  output pcie_stream_pkg::lane_beat_t m_beat_o,
  output logic                       m_valid_o,
  input  logic                       m_ready_i
);

  localparam int LDW = pcie_stream_pkg::LANE_DATA_WIDTH;
  localparam int LKW = pcie_stream_pkg::LANE_KEEP_WIDTH;

  // holding register for one wide beat
  pcie_stream_pkg::app_beat_t held_q;
  logic                       full_q;
  // low half goes out first, then the high half
  logic                       hi_sel_q;

  logic upper_empty;
  logic final_half;
  logic take;
  logic accept;

  // ------------------------------
  // half selection
  // ------------------------------

  // a last beat with no upper bytes ends on its low half
  assign upper_empty = (held_q.keep[LKW +: LKW] == '0);
  assign final_half  = hi_sel_q || (held_q.last && upper_empty);

  always_comb begin
    m_beat_o.user = held_q.user;
    if (hi_sel_q) begin
      m_beat_o.data = held_q.data[LDW +: LDW];
      m_beat_o.keep = held_q.keep[LKW +: LKW];
      m_beat_o.last = held_q.last;
    end else begin
      m_beat_o.data = held_q.data[0 +: LDW];
      m_beat_o.keep = held_q.keep[0 +: LKW];
      m_beat_o.last = held_q.last && upper_empty;
    end
  end

  assign m_valid_o = full_q;

  // ------------------------------
  // handshake
  // ------------------------------

  assign take      = full_q && m_ready_i;
  // nothing enters before the link is up
  assign s_ready_o = link_up_i && (!full_q || (take && final_half));
  assign accept    = s_valid_i && s_ready_o;

  always_ff @(posedge PIPE_PCLK_IN or negedge clock_locked) begin
    if (!clock_locked) begin
      full_q   <= 1'b0;
      hi_sel_q <= 1'b0;
    end else if (accept) begin
      full_q   <= 1'b1;
      hi_sel_q <= 1'b0;
    end else if (take) begin
      if (final_half) begin
        full_q   <= 1'b0;
        hi_sel_q <= 1'b0;
      end else begin
        hi_sel_q <= 1'b1;
      end
    end
  end

  // payload
  always_ff @(posedge PIPE_PCLK_IN) begin
    if (accept) begin
      held_q <= s_beat_i;
    end
  end

endmodule

//--- logic/axis_width_up.sv
`timescale 1ns/1ps

module axis_width_up (
  input  logic                       PIPE_PCLK_IN,
  input  logic                       clock_locked,

  input  pcie_stream_pkg::lane_beat_t s_beat_i,
  input  logic                       s_valid_i,
  output logic                       s_ready_o,

  output pcie_stream_pkg::app_beat_t  m_beat_o,
  output logic                       m_valid_o,
  input  logic                       m_ready_i
);

  localparam int LDW = pcie_stream_pkg::LANE_DATA_WIDTH;
  localparam int LKW = pcie_stream_pkg::LANE_KEEP_WIDTH;

  // low half waiting for its partner
  logic [LDW-1:0] lo_data_q;
  logic [LKW-1:0] lo_keep_q;
  logic           lo_have_q;

  // joined output beat
  pcie_stream_pkg::app_beat_t out_q;
  pcie_stream_pkg::app_beat_t joined;
  logic                       out_full_q;

  logic take;
  logic accept;
  logic close;

  // ------------------------------
  // handshake
  // ------------------------------

  assign take      = out_full_q && m_ready_i;
  assign s_ready_o = !out_full_q || m_ready_i;
  assign accept    = s_valid_i && s_ready_o;

  // second half, or a low half marked last, completes the wide beat
  assign close = accept && (lo_have_q || s_beat_i.last);

  // ------------------------------
  // join
  // ------------------------------

  always_comb begin
    joined.last = s_beat_i.last;
    joined.user = s_beat_i.user;
    if (lo_have_q) begin
      joined.data = {s_beat_i.data, lo_data_q};
      joined.keep = {s_beat_i.keep, lo_keep_q};
    end else begin
      // short last beat, upper half empty
      joined.data = {{LDW{1'b0}}, s_beat_i.data};
      joined.keep = {{LKW{1'b0}}, s_beat_i.keep};
    end
  end

  always_ff @(posedge PIPE_PCLK_IN or negedge clock_locked) begin
    if (!clock_locked) begin
      lo_have_q  <= 1'b0;
      out_full_q <= 1'b0;
    end else begin
      if (accept) begin
        lo_have_q <= !close;
      end
      if (close) begin
        out_full_q <= 1'b1;
      end else if (take) begin
        out_full_q <= 1'b0;
      end
    end
  end

  // payload
  always_ff @(posedge PIPE_PCLK_IN) begin
    if (accept && !close) begin
      lo_data_q <= s_beat_i.data;
      lo_keep_q <= s_beat_i.keep;
    end
    if (close) begin
      out_q <= joined;
    end
  end

  assign m_beat_o  = out_q;
  assign m_valid_o = out_full_q;

endmodule

//--- logic/lock_link_ctrl.sv
`timescale 1ns/1ps

module lock_link_ctrl #(
  parameter int LINK_SETTLE_CYCLES = pcie_stream_pkg::LINK_SETTLE_CYCLES_DEFAULT
) (
  input  logic PIPE_PCLK_IN,
  input  logic clock_locked,
  output logic link_up_o
);

  // counter wide enough for the settle count
  localparam int CNT_W = $clog2(LINK_SETTLE_CYCLES + 1);
  localparam logic [CNT_W-1:0] SETTLE_LAST = CNT_W'(LINK_SETTLE_CYCLES - 1);

  logic             lock_q;
  logic [CNT_W-1:0] settle_cnt;
  logic             link_up_q;

  // ------------------------------
  // lock flag
  // ------------------------------

  // clears at once when the clock drops lock, sets on the next edge
  always_ff @(posedge PIPE_PCLK_IN or negedge clock_locked) begin
    if (!clock_locked) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= 1'b1;
    end
  end

  // ------------------------------
  // settling counter
  // ------------------------------

  // counts edges once locked; link-up sticks until the next reset
  always_ff @(posedge PIPE_PCLK_IN or negedge clock_locked) begin
    if (!clock_locked) begin
      settle_cnt <= '0;
      link_up_q  <= 1'b0;
    end else if (lock_q && !link_up_q) begin
      if (settle_cnt == SETTLE_LAST) begin
        link_up_q <= 1'b1;
      end else begin
        settle_cnt <= settle_cnt + CNT_W'(1);
      end
    end
  end

  assign link_up_o = link_up_q;

endmodule

//--- logic/pcie_stream_pkg.sv
package pcie_stream_pkg;

  // ------------------------------
  // stream widths
  // ------------------------------

  // application side, 64-bit TLP stream
  localparam int APP_DATA_WIDTH = 64;

  // lane side, one 32-bit PIPE lane
  localparam int LANE_DATA_WIDTH = 32;

  // one keep bit per byte
  localparam int APP_KEEP_WIDTH  = APP_DATA_WIDTH / 8;
  localparam int LANE_KEEP_WIDTH = LANE_DATA_WIDTH / 8;

  // sideband tag carried with every beat
  localparam int USER_WIDTH = 5;

  // ------------------------------
  // link bring-up
  // ------------------------------

  // edges from lock to link-up
  localparam int LINK_SETTLE_CYCLES_DEFAULT = 16;

  // ------------------------------
  // beat types
  // ------------------------------

  // full-width beat, 78 bits
  typedef struct packed {
    logic [APP_DATA_WIDTH-1:0] data;
    logic [APP_KEEP_WIDTH-1:0] keep;
    logic                      last;
    logic [USER_WIDTH-1:0]     user;
  } app_beat_t;

  // lane-width beat, 42 bits
  typedef struct packed {
    logic [LANE_DATA_WIDTH-1:0] data;
    logic [LANE_KEEP_WIDTH-1:0] keep;
    logic                       last;
    logic [USER_WIDTH-1:0]      user;
  } lane_beat_t;

endpackage

//--- logic/pcie_stream_top.sv
`timescale 1ns/1ps

module pcie_stream_top #(
  parameter int LINK_SETTLE_CYCLES = pcie_stream_pkg::LINK_SETTLE_CYCLES_DEFAULT
) (
  input  logic                      PIPE_PCLK_IN,
  input  logic                      clock_locked,

  input  pcie_stream_pkg::app_beat_t in_beat_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,

  output pcie_stream_pkg::app_beat_t out_beat_o,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,

  output logic                      link_up_o
);

  // lane loopback, stands in for the link
  pcie_stream_pkg::lane_beat_t lane_beat;
  logic                        lane_valid;
  logic                        lane_ready;

  // ------------------------------
  // link bring-up
  // ------------------------------

  lock_link_ctrl #(
    .LINK_SETTLE_CYCLES(LINK_SETTLE_CYCLES)
  ) u_lock_link_ctrl (
    .PIPE_PCLK_IN(PIPE_PCLK_IN),
    .clock_locked(clock_locked),
    .link_up_o   (link_up_o)
  );

  // ------------------------------
  // 64 to 32 and back
  // ------------------------------

  axis_width_down u_width_down (
    .PIPE_PCLK_IN(PIPE_PCLK_IN),
    .clock_locked(clock_locked),
    .link_up_i   (link_up_o),
    .s_beat_i    (in_beat_i),
    .s_valid_i   (in_valid_i),
    .s_ready_o   (in_ready_o),
    .m_beat_o    (lane_beat),
    .m_valid_o   (lane_valid),
    .m_ready_i   (lane_ready)
  );

  axis_width_up u_width_up (
    .PIPE_PCLK_IN(PIPE_PCLK_IN),
    .clock_locked(clock_locked),
    .s_beat_i    (lane_beat),
    .s_valid_i   (lane_valid),
    .s_ready_o   (lane_ready),
    .m_beat_o    (out_beat_o),
    .m_valid_o   (out_valid_o),
    .m_ready_i   (out_ready_i)
  );

endmodule
